// ==== design/cpuPkg.sv ====
// word-sized struct fields are fixed at 16 bits, so every WordWidth parameter must stay 16
`default_nettype none

package cpuPkg;

    typedef enum logic [2:0] {
        opMov    = 3'd0,
        opMvtOrB = 3'd1,
        opAdd    = 3'd2,
        opSub    = 3'd3,
        opLd     = 3'd4,
        opSt     = 3'd5,
        opAnd    = 3'd6,
        opHalt   = 3'd7
    } opcodeT;

    typedef enum logic [1:0] {
        aluPass = 2'd0,
        aluAdd  = 2'd1,
        aluSub  = 2'd2,
        aluAnd  = 2'd3
    } aluOpT;

    // instruction word as it sits in memory, bit 15 first
    typedef struct packed {
        opcodeT     opcode;
        logic       useImm;
        logic [2:0] rX;
        logic [8:0] imm;        // rY is the low three bits when useImm is clear
    } instrT;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [15:0] addr;
        logic [15:0] data;
    } memReqT;

    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rX;
        logic [2:0] rY;
        logic       useImm;
        logic [8:0] imm;
        aluOpT      aluOp;
        logic       isLoad;
        logic       isStore;
        logic       isBranch;
        logic       isMvt;
        logic       isHalt;
        logic       writesReg;
        logic       readsRy;
    } decodedT;

    typedef struct packed {
        logic        valid;
        decodedT     dec;
        logic [15:0] pc;        // address of this instruction
        logic [15:0] op1;       // rX value, also the store data
        logic [15:0] op2;       // immediate or rY, also the memory address
        logic [15:0] result;
    } stageT;

endpackage

`default_nettype wire

// ==== design/registerFile.sv ====
// eight registers cleared by reset; r7 is never written because decode drops its write flag
`timescale 1ns/1ps
`default_nettype none

module registerFile #(
    parameter int WordWidth = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic [2:0]           readAddrA,
    input  logic [2:0]           readAddrB,
    output logic [WordWidth-1:0] readDataA,
    output logic [WordWidth-1:0] readDataB,
    input  logic                 writeEnable,
    input  logic [2:0]           writeAddr,
    input  logic [WordWidth-1:0] writeData
);

    logic [WordWidth-1:0] regs [8];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-through lets decode read a value in the same cycle writeback stores it
    assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

`default_nettype wire

// ==== design/decodeUnit.sv ====
// purely combinational; decodes whatever word is presented, the caller qualifies it with valid
`timescale 1ns/1ps
`default_nettype none

module decodeUnit #(
    parameter int WordWidth = 16
) (
    input  logic [WordWidth-1:0] instr,
    output cpuPkg::decodedT      decoded
);

    cpuPkg::instrT fields;

    assign fields = cpuPkg::instrT'(instr);

    always_comb begin
        decoded         = '0;
        decoded.opcode  = fields.opcode;
        decoded.rX      = fields.rX;
        decoded.rY      = fields.imm[2:0];
        decoded.useImm  = fields.useImm;
        decoded.imm     = fields.imm;
        decoded.aluOp   = cpuPkg::aluPass;
        decoded.readsRy = !fields.useImm;   // most classes take op2 from rY
        case (fields.opcode)
            cpuPkg::opMov: begin
                decoded.writesReg = 1'b1;
            end
            cpuPkg::opMvtOrB: begin
                decoded.isMvt     = fields.useImm;   // flag set means mvt
                decoded.isBranch  = !fields.useImm;
                decoded.writesReg = fields.useImm;
                decoded.readsRy   = 1'b0;
            end
            cpuPkg::opAdd: begin
                decoded.aluOp     = cpuPkg::aluAdd;
                decoded.writesReg = 1'b1;
            end
            cpuPkg::opSub: begin
                decoded.aluOp     = cpuPkg::aluSub;
                decoded.writesReg = 1'b1;
            end
            cpuPkg::opAnd: begin
                decoded.aluOp     = cpuPkg::aluAnd;
                decoded.writesReg = 1'b1;
            end
            cpuPkg::opLd: begin
                decoded.isLoad    = 1'b1;
                decoded.writesReg = 1'b1;
            end
            cpuPkg::opSt: begin
                decoded.isStore = 1'b1;
            end
            default: begin
                decoded.isHalt  = 1'b1;
                decoded.readsRy = 1'b0;
            end
        endcase
        if (fields.rX == 3'd7) begin
            decoded.writesReg = 1'b0;       // r7 mirrors the PC
        end
    end

endmodule

`default_nettype wire

// ==== design/executeUnit.sv ====
// combinational ALU; branch target is the instruction's own address plus one plus offset
`timescale 1ns/1ps
`default_nettype none

module executeUnit #(
    parameter int WordWidth = 16
) (
    input  cpuPkg::stageT        stageIn,
    output logic [WordWidth-1:0] result,
    output logic                 branchTaken,
    output logic [WordWidth-1:0] branchTarget
);

    logic [WordWidth-1:0] offset;

    assign offset = {{(WordWidth-9){stageIn.dec.imm[8]}}, stageIn.dec.imm};

    always_comb begin
        case (stageIn.dec.aluOp)
            cpuPkg::aluAdd: result = stageIn.op1 + stageIn.op2;
            cpuPkg::aluSub: result = stageIn.op1 - stageIn.op2;
            cpuPkg::aluAnd: result = stageIn.op1 & stageIn.op2;
            default:        result = stageIn.op2;           // mov, and the ld/st address
        endcase
        if (stageIn.dec.isMvt) begin
            result = {stageIn.dec.imm[7:0], {(WordWidth-8){1'b0}}};  // low byte cleared
        end
    end

    assign branchTaken  = stageIn.valid && stageIn.dec.isBranch;
    assign branchTarget = stageIn.pc + 1'b1 + offset;

endmodule

`default_nettype wire

// ==== design/memoryArbiter.sv ====
// data peer always wins; a peer must hold its request until granted, reads return next cycle
`timescale 1ns/1ps
`default_nettype none

module memoryArbiter #(
    parameter int WordWidth = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  cpuPkg::memReqT       fetchReq,
    input  cpuPkg::memReqT       dataReq,
    output logic                 fetchGrant,
    output logic                 dataGrant,
    output logic                 fetchRsp,
    output logic                 dataRsp,
    output cpuPkg::memReqT       memReq,
    input  logic [WordWidth-1:0] memRdata,
    output logic [WordWidth-1:0] readData
);

    logic rspFetchQ;    // owner of the read now in the memory output register
    logic rspDataQ;

    assign dataGrant  = dataReq.valid;
    assign fetchGrant = fetchReq.valid && !dataReq.valid;
    assign memReq     = dataReq.valid ? dataReq : fetchReq;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            rspFetchQ <= 1'b0;
            rspDataQ  <= 1'b0;
        end else begin
            rspFetchQ <= fetchGrant && !fetchReq.write;
            rspDataQ  <= dataGrant && !dataReq.write;
        end
    end

    assign fetchRsp = rspFetchQ;
    assign dataRsp  = rspDataQ;
    assign readData = memRdata;       // both peers share the bus, the strobes tell them apart

    assert property (@(posedge Clock) disable iff (Reset) !(fetchGrant && dataGrant));

endmodule

`default_nettype wire

// ==== design/unifiedMemory.sv ====
// single port, contents undefined until loaded; addresses wrap at MemDepth
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory #(
    parameter int WordWidth = 16,
    parameter int MemDepth  = 256
) (
    input  logic                 Clock,
    input  cpuPkg::memReqT       memReq,
    output logic [WordWidth-1:0] rdata
);

    localparam int AddrBits = $clog2(MemDepth);

    logic [WordWidth-1:0] mem [MemDepth];
    logic [AddrBits-1:0]  index;

    assign index = memReq.addr[AddrBits-1:0];

    always_ff @(posedge Clock) begin
        if (memReq.valid && memReq.write) begin
            mem[index] <= memReq.data;
        end
        if (memReq.valid && !memReq.write) begin
            rdata <= mem[index];        // registered read, one cycle latency
        end
    end

endmodule

`default_nettype wire

// ==== design/pipelineCore.sv ====
// no forwarding, so dependents wait in decode; reads of in-flight memory responses continue while Enable is low
`timescale 1ns/1ps
`default_nettype none

module pipelineCore #(
    parameter int WordWidth = 16
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 Enable,
    output cpuPkg::memReqT       fetchReq,
    output cpuPkg::memReqT       dataReq,
    input  logic                 fetchGrant,
    input  logic                 dataGrant,
    input  logic                 fetchRsp,
    input  logic                 dataRsp,
    input  logic [WordWidth-1:0] readData,
    output logic                 halted
);

    logic [WordWidth-1:0] pc;
    logic                 dValid;
    logic [WordWidth-1:0] dPc;
    logic [WordWidth-1:0] dHeld;        // instruction kept while decode stalls
    logic [WordWidth-1:0] dInstr;
    logic [WordWidth-1:0] pcMirror;
    cpuPkg::decodedT      dDec;
    cpuPkg::stageT        dStage;
    cpuPkg::stageT        eReg;
    cpuPkg::stageT        mReg;
    cpuPkg::stageT        wReg;
    logic [WordWidth-1:0] rdA;
    logic [WordWidth-1:0] rdB;
    logic [WordWidth-1:0] exResult;
    logic [WordWidth-1:0] branchTarget;
    logic                 branchTaken;
    logic                 flush;
    logic                 hazard;
    logic                 mStall;
    logic                 dAdvance;
    logic                 haltSeen;     // a halt has left decode, fetch stops for good
    logic                 mGranted;     // load granted, response not yet back
    logic                 mRspSeen;     // load response caught while frozen
    logic [WordWidth-1:0] mData;
    logic [WordWidth-1:0] loadData;

    function automatic logic writesTo(cpuPkg::stageT s, logic [2:0] r);
        return s.valid && s.dec.writesReg && s.dec.rX == r;
    endfunction

    assign dInstr   = fetchRsp ? readData : dHeld;
    assign pcMirror = dPc + 1'b1;

    decodeUnit #(.WordWidth(WordWidth)) i_decodeUnit (
        .instr   (dInstr),
        .decoded (dDec)
    );

    registerFile #(.WordWidth(WordWidth)) i_registerFile (
        .Clock       (Clock),
        .Reset       (Reset),
        .readAddrA   (dDec.rX),
        .readAddrB   (dDec.rY),
        .readDataA   (rdA),
        .readDataB   (rdB),
        .writeEnable (wReg.valid && wReg.dec.writesReg),
        .writeAddr   (wReg.dec.rX),
        .writeData   (wReg.result)
    );

    executeUnit #(.WordWidth(WordWidth)) i_executeUnit (
        .stageIn      (eReg),
        .result       (exResult),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    // writeback needs no check thanks to register file write-through
    assign hazard = dValid && (writesTo(eReg, dDec.rX) || writesTo(mReg, dDec.rX) ||
                    (dDec.readsRy && (writesTo(eReg, dDec.rY) || writesTo(mReg, dDec.rY))));
    assign mStall = mReg.valid && ((mReg.dec.isStore && !dataGrant) ||
                    (mReg.dec.isLoad && !(dataRsp || mRspSeen)));
    assign loadData = dataRsp ? readData : mData;
    assign flush    = branchTaken && !mStall;
    assign dAdvance = dValid && !hazard && !mStall;

    always_comb begin
        dStage       = '0;
        dStage.valid = dAdvance && !flush;
        dStage.dec   = dDec;
        dStage.pc    = dPc;
        dStage.op1   = (dDec.rX == 3'd7) ? pcMirror : rdA;
        if (dDec.useImm) begin
            dStage.op2 = {{(WordWidth-9){1'b0}}, dDec.imm};
        end else begin
            dStage.op2 = (dDec.rY == 3'd7) ? pcMirror : rdB;
        end
    end

    always_comb begin
        fetchReq       = '0;
        fetchReq.valid = Enable && !haltSeen && !flush && !(dValid && dDec.isHalt) &&
                         (!dValid || dAdvance);
        fetchReq.addr  = pc;
        dataReq        = '0;
        dataReq.valid  = Enable && mReg.valid && (mReg.dec.isLoad || mReg.dec.isStore) &&
                         !mGranted;
        dataReq.write  = mReg.dec.isStore;
        dataReq.addr   = mReg.result;
        dataReq.data   = mReg.op1;
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc       <= '0;
            dValid   <= 1'b0;
            eReg     <= '0;
            mReg     <= '0;
            wReg     <= '0;
            haltSeen <= 1'b0;
            halted   <= 1'b0;
            mGranted <= 1'b0;
        end else if (Enable) begin
            if (flush) begin
                pc     <= branchTarget;
                dValid <= 1'b0;
            end else if (fetchGrant) begin
                pc     <= pc + 1'b1;
                dValid <= 1'b1;
            end else if (dAdvance) begin
                dValid <= 1'b0;
            end
            if (dStage.valid && dDec.isHalt) begin
                haltSeen <= 1'b1;
            end
            if (!mStall) begin
                eReg        <= dStage;
                mReg        <= eReg;
                mReg.result <= exResult;
                wReg        <= mReg;
                if (mReg.dec.isLoad) begin
                    wReg.result <= loadData;
                end
                if (mReg.valid && mReg.dec.isHalt) begin
                    halted <= 1'b1;
                end
                mGranted <= 1'b0;
            end else begin
                wReg.valid <= 1'b0;                 // bubble behind the waiting access
                if (dataGrant) begin
                    mGranted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mRspSeen <= 1'b0;
        end else if (Enable && !mStall) begin
            mRspSeen <= 1'b0;
        end else if (dataRsp) begin
            mRspSeen <= 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        dHeld <= dInstr;
        mData <= loadData;
        if (Enable && fetchGrant) begin
            dPc <= pc;
        end
    end

    // execute keeps its instruction while memory waits on the arbiter
    assert property (@(posedge Clock) disable iff (Reset)
        Enable && mStall && eReg.valid |=> eReg.valid && eReg.pc == $past(eReg.pc));

    assert property (@(posedge Clock) disable iff (Reset) halted |=> halted);

endmodule

`default_nettype wire

// ==== design/cpuTop.sv ====
// loader writes reach memory only while Enable is low, and Enable low also freezes the core
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int WordWidth = 16,
    parameter int MemDepth  = 256
) (
    input  logic                 Clock,
    input  logic                 Reset,
    input  logic                 Enable,
    input  logic                 LoadWrite,
    input  logic [WordWidth-1:0] LoadAddr,
    input  logic [WordWidth-1:0] LoadData,
    output logic                 StoreStrobe,
    output logic [WordWidth-1:0] StoreAddr,
    output logic [WordWidth-1:0] StoreData,
    output logic                 Halted
);

    cpuPkg::memReqT       fetchReq;
    cpuPkg::memReqT       dataReq;
    cpuPkg::memReqT       arbReq;
    cpuPkg::memReqT       memReq;
    logic                 fetchGrant;
    logic                 dataGrant;
    logic                 fetchRsp;
    logic                 dataRsp;
    logic [WordWidth-1:0] memRdata;
    logic [WordWidth-1:0] readData;

    pipelineCore #(.WordWidth(WordWidth)) i_pipelineCore (
        .Clock      (Clock),
        .Reset      (Reset),
        .Enable     (Enable),
        .fetchReq   (fetchReq),
        .dataReq    (dataReq),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .fetchRsp   (fetchRsp),
        .dataRsp    (dataRsp),
        .readData   (readData),
        .halted     (Halted)
    );

    memoryArbiter #(.WordWidth(WordWidth)) i_memoryArbiter (
        .Clock      (Clock),
        .Reset      (Reset),
        .fetchReq   (fetchReq),
        .dataReq    (dataReq),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .fetchRsp   (fetchRsp),
        .dataRsp    (dataRsp),
        .memReq     (arbReq),
        .memRdata   (memRdata),
        .readData   (readData)
    );

    always_comb begin
        memReq = arbReq;
        if (!Enable) begin
            memReq.valid = LoadWrite;   // loader owns the port while frozen
            memReq.write = 1'b1;
            memReq.addr  = LoadAddr;
            memReq.data  = LoadData;
        end
    end

    unifiedMemory #(.WordWidth(WordWidth), .MemDepth(MemDepth)) i_unifiedMemory (
        .Clock  (Clock),
        .memReq (memReq),
        .rdata  (memRdata)
    );

    // store trace taps the granted data request
    assign StoreStrobe = dataGrant && dataReq.write;
    assign StoreAddr   = dataReq.addr;
    assign StoreData   = dataReq.data;

endmodule

`default_nettype wire

// ==== tests/tbPrograms.svh ====
// programs load from address 0 and end in halt; expected store lists follow the ISA rule only
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic logic [15:0] immWord(cpuPkg::opcodeT op, logic [2:0] rx, logic [8:0] imm);
    return {op, 1'b1, rx, imm};
endfunction

function automatic logic [15:0] regWord(cpuPkg::opcodeT op, logic [2:0] rx, logic [2:0] ry);
    return {op, 1'b0, rx, 6'b0, ry};
endfunction

function automatic logic [15:0] branchWord(logic [8:0] offset);
    return {cpuPkg::opMvtOrB, 1'b0, 3'd0, offset};    // target is own address + 1 + offset
endfunction

function automatic logic [15:0] haltWord();
    return {cpuPkg::opHalt, 13'b0};
endfunction

// fills progWords, expAddr and expData for one program
task automatic buildProgram(input int num, input logic [15:0] a, input logic [15:0] b);
    logic [15:0] k;
    progWords = {};
    expAddr   = {};
    expData   = {};
    case (num)
        1: begin    // random operands built with mvt and add, then the four ALU classes
            progWords = {immWord(cpuPkg::opMvtOrB, 3'd1, {1'b0, a[15:8]}),
                         immWord(cpuPkg::opAdd, 3'd1, {1'b0, a[7:0]}),
                         immWord(cpuPkg::opMvtOrB, 3'd2, {1'b0, b[15:8]}),
                         immWord(cpuPkg::opAdd, 3'd2, {1'b0, b[7:0]}),
                         regWord(cpuPkg::opMov, 3'd3, 3'd1), regWord(cpuPkg::opAdd, 3'd3, 3'd2),
                         immWord(cpuPkg::opSt, 3'd3, 9'h080),
                         regWord(cpuPkg::opMov, 3'd4, 3'd1), regWord(cpuPkg::opSub, 3'd4, 3'd2),
                         immWord(cpuPkg::opSt, 3'd4, 9'h081),
                         regWord(cpuPkg::opMov, 3'd5, 3'd1), regWord(cpuPkg::opAnd, 3'd5, 3'd2),
                         immWord(cpuPkg::opSt, 3'd5, 9'h082),
                         regWord(cpuPkg::opMov, 3'd6, 3'd2), immWord(cpuPkg::opSt, 3'd6, 9'h083),
                         haltWord(), immWord(cpuPkg::opSt, 3'd1, 9'h084)};
            expAddr   = {16'h0080, 16'h0081, 16'h0082, 16'h0083};
            expData   = {16'(a + b), 16'(a - b), a & b, b};
        end
        2: begin    // store then load of the same word, dependent add right after the load
            k = 16'h1200 + 16'h0034;
            progWords = {immWord(cpuPkg::opMvtOrB, 3'd1, 9'h012),
                         immWord(cpuPkg::opAdd, 3'd1, 9'h034),
                         immWord(cpuPkg::opSt, 3'd1, 9'h090), immWord(cpuPkg::opSt, 3'd1, 9'h091),
                         immWord(cpuPkg::opLd, 3'd2, 9'h091), immWord(cpuPkg::opAdd, 3'd2, 9'h001),
                         immWord(cpuPkg::opSt, 3'd2, 9'h092), immWord(cpuPkg::opMov, 3'd3, 9'h093),
                         regWord(cpuPkg::opSt, 3'd2, 3'd3), regWord(cpuPkg::opLd, 3'd4, 3'd3),
                         regWord(cpuPkg::opSub, 3'd4, 3'd1), immWord(cpuPkg::opSt, 3'd4, 9'h094),
                         haltWord(), immWord(cpuPkg::opSt, 3'd1, 9'h095)};
            expAddr   = {16'h0090, 16'h0091, 16'h0092, 16'h0093, 16'h0094};
            expData   = {k, k, 16'(k + 1), 16'(k + 1), 16'(k + 1 - k)};
        end
        default: begin  // forward skip, then a loop that ends by writing a halt over its own top
            progWords = {immWord(cpuPkg::opMov, 3'd1, 9'h011), branchWord(9'd2),
                         immWord(cpuPkg::opSt, 3'd1, 9'h0A0), immWord(cpuPkg::opSt, 3'd1, 9'h0A1),
                         immWord(cpuPkg::opMvtOrB, 3'd6, 9'h0E0),
                         immWord(cpuPkg::opMov, 3'd3, 9'h005), immWord(cpuPkg::opMov, 3'd2, 9'h020),
                         immWord(cpuPkg::opAdd, 3'd2, 9'h001), immWord(cpuPkg::opSt, 3'd2, 9'h0A2),
                         regWord(cpuPkg::opSt, 3'd6, 3'd3), immWord(cpuPkg::opAdd, 3'd3, 9'h001),
                         branchWord(9'h1FB), immWord(cpuPkg::opSt, 3'd1, 9'h0A3)};
            for (int i = 1; i <= 3; i++) begin
                expAddr.push_back(16'h00A2);
                expData.push_back(16'(16'h0020 + i));   // loop counter
                expAddr.push_back(16'(4 + i));          // pointer walks up to the loop top at 7
                expData.push_back(haltWord());
            end
        end
    endcase
endtask

`endif

// ==== tests/cpuTopTb.sv ====
// each test resets the DUT and reloads memory; results are seen only through the store trace
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb;

    localparam int WordWidth  = 16;
    localparam int MemDepth   = 256;
    localparam int NumTests   = 5;
    localparam int TailCycles = 20;                 // cycles watched after Halted
    localparam int ProgramOf [NumTests] = '{1, 2, 3, 2, 3};

    logic        Clock;
    logic        Reset;
    logic        Enable;
    logic        LoadWrite;
    logic [15:0] LoadAddr;
    logic [15:0] LoadData;
    logic        StoreStrobe;
    logic [15:0] StoreAddr;
    logic [15:0] StoreData;
    logic        Halted;

    logic [15:0] progWords [$];
    logic [15:0] expAddr [$];
    logic [15:0] expData [$];
    logic [15:0] opA;
    logic [15:0] opB;
    int          expCount;
    int          storeIndex;
    int          errorCount;
    int          testsPassed;
    int          testsFailed;
    int          cycleCount;
    int          cycleLimit;

    `include "tbPrograms.svh"

    cpuTop #(.WordWidth(WordWidth), .MemDepth(MemDepth)) i_cpuTop (
        .Clock       (Clock),
        .Reset       (Reset),
        .Enable      (Enable),
        .LoadWrite   (LoadWrite),
        .LoadAddr    (LoadAddr),
        .LoadData    (LoadData),
        .StoreStrobe (StoreStrobe),
        .StoreAddr   (StoreAddr),
        .StoreData   (StoreData),
        .Halted      (Halted)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        if (!Reset && StoreStrobe && storeIndex < expCount) begin
            assert (StoreAddr == expAddr[storeIndex]) else begin
                $display("ERROR %0t StoreAddr expected %h actual %h",
                         $time, expAddr[storeIndex], StoreAddr);
                errorCount++;
            end
            assert (StoreData == expData[storeIndex]) else begin
                $display("ERROR %0t StoreData expected %h actual %h",
                         $time, expData[storeIndex], StoreData);
                errorCount++;
            end
            storeIndex++;
        end
    end

    // covers skipped stores and anything stored after halt
    assert property (@(posedge Clock) disable iff (Reset) StoreStrobe |-> storeIndex < expCount)
        else begin
            $display("unexpected store at %0t to address %h, none left to expect", $time, StoreAddr);
            errorCount++;
        end

    assert property (@(posedge Clock) disable iff (Reset) Halted |=> Halted)
        else begin
            $display("Halted dropped at %0t before reset", $time);
            errorCount++;
        end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("run stopped after %0d cycles, a program never reached halt", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic runTest(input int testNum, input int progNum, input bit withPauses);
        int startErrors;
        int waited;
        startErrors = errorCount;
        buildProgram(progNum, opA, opB);
        expCount   = expAddr.size();
        storeIndex = 0;
        Reset      = 1'b1;
        Enable     = 1'b0;
        repeat (10) @(negedge Clock);
        Reset = 1'b0;
        for (int i = 0; i < progWords.size(); i++) begin
            LoadWrite = 1'b1;
            LoadAddr  = 16'(i);
            LoadData  = progWords[i];
            @(negedge Clock);
        end
        LoadWrite = 1'b0;
        Enable    = 1'b1;
        waited    = 0;
        while (!Halted) begin
            @(negedge Clock);
            waited++;
            if (withPauses) begin
                Enable = !(waited % 5 == 2 || waited % 7 == 3);     // short freezes mid-run
            end
        end
        Enable = 1'b1;
        repeat (TailCycles) @(negedge Clock);
        assert (storeIndex == expCount) else begin
            $display("test %0d saw %0d of %0d expected stores", testNum, storeIndex, expCount);
            errorCount++;
        end
        if (errorCount == startErrors) begin
            testsPassed++;
            $display("test %0d (program %0d, pauses %0d) passed", testNum, progNum, withPauses);
        end else begin
            testsFailed++;
            $display("test %0d (program %0d, pauses %0d) failed", testNum, progNum, withPauses);
        end
    endtask

    initial begin
        int totalWords;
        Reset       = 1'b1;
        Enable      = 1'b0;
        LoadWrite   = 1'b0;
        LoadAddr    = '0;
        LoadData    = '0;
        expCount    = 0;
        storeIndex  = 0;
        errorCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        void'($urandom(28));
        opA         = 16'($urandom);
        opB         = 16'($urandom);
        totalWords  = 0;
        for (int t = 0; t < NumTests; t++) begin
            buildProgram(ProgramOf[t], opA, opB);
            totalWords += progWords.size();
        end
        cycleLimit = 40 * totalWords;
        for (int t = 0; t < NumTests; t++) begin
            runTest(t + 1, ProgramOf[t], t >= 3);   // last two rerun programs with freezes
        end
        $display("%0d tests passed, %0d failed, %0d errors", testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+tests
design/cpuPkg.sv
design/registerFile.sv
design/decodeUnit.sv
design/executeUnit.sv
design/memoryArbiter.sv
design/unifiedMemory.sv
design/pipelineCore.sv
design/cpuTop.sv
tests/cpuTopTb.sv
